// ==== rtl/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Boot region field of a fetch address
`define BMEM_SEL_ADDR_HIGH  31
`define BMEM_SEL_ADDR_LOW   28
`define BMEM_ADDR_MATCH     4'h1

// Main memory, word addressed
`define DMEM_DEPTH_WORDS    1024
`define DMEM_ADDR_BITS      10

// Boot memory
`define BMEM_DEPTH_WORDS    64
`define BMEM_ADDR_BITS      6

// Cache geometry, single-word lines
`define CACHE_INDEX_BITS    4
`define CACHE_TAG_BITS      26

`endif

// ==== rtl/mem_pkg.sv ====
`include "mem_defs.svh"

package mem_pkg;

    // Same 32-bit word, read plain or split for cache lookup
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]   tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [1:0]                   offset;  // Byte within word
    } cache_addr_s;

    typedef union packed {
        logic [31:0] word;
        cache_addr_s cache;
    } mem_addr_u;

    typedef struct packed {
        logic [31:0] addr;
        logic        req;
    } type_if2icache_s;

    typedef struct packed {
        logic [31:0] r_data;
        logic        ack;
    } type_icache2if_s;

    typedef struct packed {
        logic [31:0] addr;
        logic        req;
    } type_icache2imem_s;

    typedef struct packed {
        logic [31:0] r_data;
        logic        ack;
    } type_imem2icache_s;

    // Wishbone classic master side
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] w_data;
        logic [3:0]  sel_byte;
        logic        w_en;
        logic        cyc;
        logic        stb;
    } type_dbus2peri_s;

    typedef struct packed {
        logic [31:0] r_data;
        logic        ack;
    } type_peri2dbus_s;

    typedef struct packed {
        logic [31:0] paddr;
        logic        r_req;
    } type_mmu2dmem_s;

    typedef struct packed {
        logic [31:0] r_data;
        logic        r_valid;
    } type_dmem2mmu_s;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] w_data;
        logic [3:0]  sel_byte;
        logic        w_en;
        logic        req;
    } type_lsummu2dcache_s;

    typedef struct packed {
        logic [31:0] r_data;
        logic        ack;
    } type_dcache2lsummu_s;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] w_data;
        logic [3:0]  sel_byte;
        logic        w_en;
        logic        req;
    } type_dcache2dmem_s;

    typedef struct packed {
        logic [31:0] r_data;
        logic        ack;
    } type_dmem2dcache_s;

    typedef enum logic [1:0] {
        DMEM_IDLE,
        DMEM_LSU,
        DMEM_MMU
    } type_dmem_bus_states_e;

    // Lookup, memory wait and respond, shared by both caches
    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_MEM,
        CACHE_RESP
    } type_cache_states_e;

endpackage : mem_pkg

// ==== rtl/dmem_arbiter.sv ====
`timescale 1ns/1ps

module dmem_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  mem_pkg::type_dbus2peri_s     dbus_i,
    input  logic                         dmem_sel_i,
    input  mem_pkg::type_mmu2dmem_s      mmu_i,
    input  mem_pkg::type_dcache2lsummu_s dcache_rsp_i,
    output mem_pkg::type_lsummu2dcache_s dcache_req_o,
    output mem_pkg::type_peri2dbus_s     dbus_o,
    output mem_pkg::type_dmem2mmu_s      mmu_o
);
    import mem_pkg::*;

    type_dmem_bus_states_e state_q, state_d;
    type_lsummu2dcache_s   lsu_fwd;
    type_lsummu2dcache_s   mmu_fwd;
    logic                  lsu_valid;

    assign lsu_valid = dmem_sel_i & dbus_i.cyc & dbus_i.stb;  // Valid Wishbone cycle

    always_comb begin
        lsu_fwd.addr     = dbus_i.addr;
        lsu_fwd.w_data   = dbus_i.w_data;
        lsu_fwd.sel_byte = dbus_i.sel_byte;
        lsu_fwd.w_en     = dbus_i.w_en;
        lsu_fwd.req      = lsu_valid;
        // Walker only reads
        mmu_fwd.addr     = mmu_i.paddr;
        mmu_fwd.w_data   = '0;
        mmu_fwd.sel_byte = '0;
        mmu_fwd.w_en     = 1'b0;
        mmu_fwd.req      = mmu_i.r_req;
    end

    always_comb begin
        state_d      = state_q;
        dcache_req_o = '0;
        dbus_o       = '0;
        mmu_o        = '0;
        case (state_q)
            DMEM_IDLE: begin
                if (lsu_valid) begin  // LSU wins a tie
                    dcache_req_o = lsu_fwd;
                    state_d      = DMEM_LSU;
                end else if (mmu_i.r_req) begin
                    dcache_req_o = mmu_fwd;
                    state_d      = DMEM_MMU;
                end
            end
            DMEM_LSU: begin
                dcache_req_o = lsu_fwd;
                if (dcache_rsp_i.ack) begin
                    dbus_o.r_data = dcache_rsp_i.r_data;
                    dbus_o.ack    = 1'b1;
                    state_d       = DMEM_IDLE;
                end
            end
            DMEM_MMU: begin
                dcache_req_o = mmu_fwd;
                if (dcache_rsp_i.ack) begin
                    mmu_o.r_data  = dcache_rsp_i.r_data;
                    mmu_o.r_valid = 1'b1;
                    state_d       = DMEM_IDLE;
                end
            end
            default: state_d = DMEM_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= DMEM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : dmem_arbiter

// ==== rtl/icache.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module icache (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_pkg::type_if2icache_s   if2icache_i,
    input  logic                       boot_hit_i,
    output mem_pkg::type_icache2if_s   icache2if_o,
    input  mem_pkg::type_imem2icache_s imem2icache_i,
    output mem_pkg::type_icache2imem_s icache2imem_o
);
    import mem_pkg::*;

    type_cache_states_e                state_q;
    logic [2**`CACHE_INDEX_BITS-1:0]   valid_q;
    logic [`CACHE_TAG_BITS-1:0]        tag_q  [2**`CACHE_INDEX_BITS];
    logic [31:0]                       data_q [2**`CACHE_INDEX_BITS];
    logic [31:0]                       addr_q;     // Address of the pending miss
    logic [31:0]                       rdata_q;
    mem_addr_u                         in_addr;
    mem_addr_u                         miss_addr;
    logic                              in_hit;
    logic                              accept;

    assign in_addr.word   = if2icache_i.addr;
    assign miss_addr.word = addr_q;
    assign in_hit = valid_q[in_addr.cache.index]
                    && (tag_q[in_addr.cache.index] == in_addr.cache.tag);
    // Boot fetches belong to the boot memory
    assign accept = (state_q == CACHE_IDLE) & if2icache_i.req & ~boot_hit_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= CACHE_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                CACHE_IDLE: if (accept) state_q <= in_hit ? CACHE_RESP : CACHE_MEM;
                CACHE_MEM: begin
                    if (imem2icache_i.ack) begin
                        valid_q[miss_addr.cache.index] <= 1'b1;
                        state_q <= CACHE_RESP;
                    end
                end
                CACHE_RESP: state_q <= CACHE_IDLE;  // Ack pulse
                default:    state_q <= CACHE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= if2icache_i.addr;
            rdata_q <= data_q[in_addr.cache.index];
        end
        if ((state_q == CACHE_MEM) && imem2icache_i.ack) begin  // Line refill
            tag_q[miss_addr.cache.index]  <= miss_addr.cache.tag;
            data_q[miss_addr.cache.index] <= imem2icache_i.r_data;
            rdata_q <= imem2icache_i.r_data;
        end
    end

    assign icache2imem_o.addr  = addr_q;
    assign icache2imem_o.req   = (state_q == CACHE_MEM);
    assign icache2if_o.r_data  = rdata_q;
    assign icache2if_o.ack     = (state_q == CACHE_RESP);

endmodule : icache

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module dcache (
    input  logic                         clk,
    input  logic                         rst_n,
    input  mem_pkg::type_lsummu2dcache_s lsummu2dcache_i,
    output mem_pkg::type_dcache2lsummu_s dcache2lsummu_o,
    input  mem_pkg::type_dmem2dcache_s   dmem2dcache_i,
    output mem_pkg::type_dcache2dmem_s   dcache2dmem_o,
    input  logic                         flush_i
);
    import mem_pkg::*;

    type_cache_states_e                state_q;
    type_lsummu2dcache_s               req_q;      // Request being served
    logic [31:0]                       rdata_q;
    logic                              flush_q;    // Flush held until idle
    logic [2**`CACHE_INDEX_BITS-1:0]   valid_q;
    logic [`CACHE_TAG_BITS-1:0]        tag_q  [2**`CACHE_INDEX_BITS];
    logic [31:0]                       data_q [2**`CACHE_INDEX_BITS];
    mem_addr_u                         in_addr;
    mem_addr_u                         hold_addr;
    logic                              in_hit, hold_hit;
    logic                              flush_now, accept, mem_done;

    assign in_addr.word   = lsummu2dcache_i.addr;
    assign hold_addr.word = req_q.addr;
    assign in_hit   = valid_q[in_addr.cache.index]
                      && (tag_q[in_addr.cache.index] == in_addr.cache.tag);
    assign hold_hit = valid_q[hold_addr.cache.index]
                      && (tag_q[hold_addr.cache.index] == hold_addr.cache.tag);
    assign flush_now = flush_i | flush_q;
    assign accept    = (state_q == CACHE_IDLE) & lsummu2dcache_i.req & ~flush_now;
    assign mem_done  = (state_q == CACHE_MEM) & dmem2dcache_i.ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= CACHE_IDLE;
            flush_q <= 1'b0;
            valid_q <= '0;
        end else begin
            case (state_q)
                CACHE_IDLE: begin
                    if (flush_now) begin  // Request waits a cycle
                        valid_q <= '0;
                        flush_q <= 1'b0;
                    end else if (accept) begin
                        // Writes always go through to memory
                        state_q <= (in_hit && !lsummu2dcache_i.w_en) ? CACHE_RESP : CACHE_MEM;
                    end
                end
                CACHE_MEM: begin
                    flush_q <= flush_q | flush_i;
                    if (dmem2dcache_i.ack) begin
                        if (!req_q.w_en) valid_q[hold_addr.cache.index] <= 1'b1;
                        state_q <= CACHE_RESP;
                    end
                end
                CACHE_RESP: begin
                    flush_q <= flush_q | flush_i;
                    state_q <= CACHE_IDLE;
                end
                default: state_q <= CACHE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q   <= lsummu2dcache_i;
            rdata_q <= data_q[in_addr.cache.index];  // Hit data
        end
        if (mem_done && !req_q.w_en) begin  // Read miss fill
            tag_q[hold_addr.cache.index]  <= hold_addr.cache.tag;
            data_q[hold_addr.cache.index] <= dmem2dcache_i.r_data;
            rdata_q <= dmem2dcache_i.r_data;
        end else if (mem_done && hold_hit) begin
            // Merge enabled bytes into the cached copy
            for (int b = 0; b < 4; b++) begin
                if (req_q.sel_byte[b]) begin
                    data_q[hold_addr.cache.index][8*b +: 8] <= req_q.w_data[8*b +: 8];
                end
            end
        end
    end

    assign dcache2dmem_o.addr     = req_q.addr;
    assign dcache2dmem_o.w_data   = req_q.w_data;
    assign dcache2dmem_o.sel_byte = req_q.sel_byte;
    assign dcache2dmem_o.w_en     = req_q.w_en;
    assign dcache2dmem_o.req      = (state_q == CACHE_MEM);
    assign dcache2lsummu_o.r_data = rdata_q;
    assign dcache2lsummu_o.ack    = (state_q == CACHE_RESP);

endmodule : dcache

// ==== rtl/dualport_mem.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module dualport_mem (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_pkg::type_icache2imem_s imem_req_i,  // Port A, read only
    output mem_pkg::type_imem2icache_s imem_rsp_o,
    input  mem_pkg::type_dcache2dmem_s dmem_req_i,  // Port B, read/write
    output mem_pkg::type_dmem2dcache_s dmem_rsp_o
);
    logic [31:0]                mem_q [`DMEM_DEPTH_WORDS];
    logic [`DMEM_ADDR_BITS-1:0] a_idx, b_idx;
    logic                       a_ack_q, b_ack_q;
    logic [31:0]                a_rdata_q, b_rdata_q;

    assign a_idx = imem_req_i.addr[`DMEM_ADDR_BITS+1:2];
    assign b_idx = dmem_req_i.addr[`DMEM_ADDR_BITS+1:2];

    // One ack per held request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_ack_q <= 1'b0;
            b_ack_q <= 1'b0;
        end else begin
            a_ack_q <= imem_req_i.req & ~a_ack_q;
            b_ack_q <= dmem_req_i.req & ~b_ack_q;
        end
    end

    always_ff @(posedge clk) begin
        a_rdata_q <= mem_q[a_idx];
        b_rdata_q <= mem_q[b_idx];
        if (dmem_req_i.req && !b_ack_q && dmem_req_i.w_en) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req_i.sel_byte[b]) mem_q[b_idx][8*b +: 8] <= dmem_req_i.w_data[8*b +: 8];
            end
        end
    end

    assign imem_rsp_o.r_data = a_rdata_q;
    assign imem_rsp_o.ack    = a_ack_q;
    assign dmem_rsp_o.r_data = b_rdata_q;
    assign dmem_rsp_o.ack    = b_ack_q;

endmodule : dualport_mem

// ==== rtl/boot_mem.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module boot_mem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_pkg::type_dbus2peri_s dbus_i,
    input  logic                     bmem_sel_i,
    output mem_pkg::type_peri2dbus_s bmem_dbus_o,
    input  mem_pkg::type_if2icache_s if_i,
    input  logic                     boot_hit_i,
    output mem_pkg::type_icache2if_s bmem_if_o
);
    logic [31:0]                mem_q [`BMEM_DEPTH_WORDS];
    logic [`BMEM_ADDR_BITS-1:0] d_idx, f_idx;
    logic                       d_cycle;
    logic                       d_ack_q, f_ack_q;
    logic [31:0]                d_rdata_q, f_rdata_q;

    assign d_idx   = dbus_i.addr[`BMEM_ADDR_BITS+1:2];
    assign f_idx   = if_i.addr[`BMEM_ADDR_BITS+1:2];
    assign d_cycle = dbus_i.cyc & dbus_i.stb & bmem_sel_i;  // Wishbone slave select

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_ack_q <= 1'b0;
            f_ack_q <= 1'b0;
        end else begin
            d_ack_q <= d_cycle & ~d_ack_q;
            f_ack_q <= if_i.req & boot_hit_i & ~f_ack_q;
        end
    end

    always_ff @(posedge clk) begin
        d_rdata_q <= mem_q[d_idx];
        f_rdata_q <= mem_q[f_idx];
        if (d_cycle && !d_ack_q && dbus_i.w_en) begin
            for (int b = 0; b < 4; b++) begin
                if (dbus_i.sel_byte[b]) mem_q[d_idx][8*b +: 8] <= dbus_i.w_data[8*b +: 8];
            end
        end
    end

    assign bmem_dbus_o.r_data = d_rdata_q;
    assign bmem_dbus_o.ack    = d_ack_q;
    assign bmem_if_o.r_data   = f_rdata_q;
    assign bmem_if_o.ack      = f_ack_q;

endmodule : boot_mem

// ==== rtl/mem_top.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_pkg::type_if2icache_s if2icache_i,    // Fetch port
    output mem_pkg::type_icache2if_s icache2if_o,
    input  mem_pkg::type_mmu2dmem_s  mmu2dmem_i,     // Page-table walker
    output mem_pkg::type_dmem2mmu_s  dmem2mmu_o,
    input  mem_pkg::type_dbus2peri_s dbus2dmem_i,    // Wishbone data bus
    output mem_pkg::type_peri2dbus_s dmem2dbus_o,
    output mem_pkg::type_peri2dbus_s bmem2dbus_o,
    input  logic                     dcache_flush_i,
    input  logic                     dmem_sel_i,     // From the bus address decoder
    input  logic                     bmem_sel_i
);
    import mem_pkg::*;

    type_icache2if_s     icache2if, bmem2if;
    type_icache2imem_s   icache2imem;
    type_imem2icache_s   imem2icache;
    type_lsummu2dcache_s lsummu2dcache;
    type_dcache2lsummu_s dcache2lsummu;
    type_dcache2dmem_s   dcache2dmem;
    type_dmem2dcache_s   dmem2dcache;
    logic                boot_hit;

    assign boot_hit = (if2icache_i.addr[`BMEM_SEL_ADDR_HIGH:`BMEM_SEL_ADDR_LOW] == `BMEM_ADDR_MATCH);

    boot_mem u_boot_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus_i      (dbus2dmem_i),
        .bmem_sel_i  (bmem_sel_i),
        .bmem_dbus_o (bmem2dbus_o),
        .if_i        (if2icache_i),
        .boot_hit_i  (boot_hit),
        .bmem_if_o   (bmem2if)
    );

    dmem_arbiter u_dmem_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .dbus_i       (dbus2dmem_i),
        .dmem_sel_i   (dmem_sel_i),
        .mmu_i        (mmu2dmem_i),
        .dcache_rsp_i (dcache2lsummu),
        .dcache_req_o (lsummu2dcache),
        .dbus_o       (dmem2dbus_o),
        .mmu_o        (dmem2mmu_o)
    );

    icache u_icache (
        .clk           (clk),
        .rst_n         (rst_n),
        .if2icache_i   (if2icache_i),
        .boot_hit_i    (boot_hit),
        .icache2if_o   (icache2if),
        .imem2icache_i (imem2icache),
        .icache2imem_o (icache2imem)
    );

    dcache u_dcache (
        .clk             (clk),
        .rst_n           (rst_n),
        .lsummu2dcache_i (lsummu2dcache),
        .dcache2lsummu_o (dcache2lsummu),
        .dmem2dcache_i   (dmem2dcache),
        .dcache2dmem_o   (dcache2dmem),
        .flush_i         (dcache_flush_i)
    );

    // Port A refills the icache, port B serves the dcache
    dualport_mem u_dualport_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_req_i (icache2imem),
        .imem_rsp_o (imem2icache),
        .dmem_req_i (dcache2dmem),
        .dmem_rsp_o (dmem2dcache)
    );

    assign icache2if_o = bmem2if.ack ? bmem2if : icache2if;  // Boot response takes the port

endmodule : mem_top

// ==== testbench/mem_top_properties.sv ====
`timescale 1ns/1ps

module mem_top_properties (
    input logic                     clk,
    input logic                     rst_n,
    input mem_pkg::type_dbus2peri_s dbus_i,
    input mem_pkg::type_icache2if_s fetch_rsp_i,
    input mem_pkg::type_dmem2mmu_s  mmu_rsp_i,
    input mem_pkg::type_peri2dbus_s dmem_bus_rsp_i,
    input mem_pkg::type_peri2dbus_s bmem_bus_rsp_i,
    output logic                    failed_o
);
    logic [3:0] acks;
    logic       reset_bad = 1'b0;
    logic       cyc_bad   = 1'b0;
    logic       excl_bad  = 1'b0;
    logic       pulse_bad = 1'b0;

    assign acks = {fetch_rsp_i.ack, mmu_rsp_i.r_valid, dmem_bus_rsp_i.ack, bmem_bus_rsp_i.ack};
    assign failed_o = reset_bad | cyc_bad | excl_bad | pulse_bad;

    // Nothing answers while reset is held
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !$rose(|acks))
        else begin
            $error("A response rose during reset");
            reset_bad = 1'b1;
        end

    // Wishbone slave acks only inside a cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_bus_rsp_i.ack |-> dbus_i.cyc)
        else begin
            $error("Data bus ack outside of a cycle");
            cyc_bad = 1'b1;
        end

    // One cache client served at a time
    one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_bus_rsp_i.ack && mmu_rsp_i.r_valid))
        else begin
            $error("LSU ack and MMU r_valid high together");
            excl_bad = 1'b1;
        end

    ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (acks & $past(acks)) == 4'b0)  // Every ack lasts one cycle
        else begin
            $error("An ack stayed high for more than one cycle");
            pulse_bad = 1'b1;
        end

endmodule : mem_top_properties

bind mem_top mem_top_properties props (
    .clk            (clk),
    .rst_n          (rst_n),
    .dbus_i         (dbus2dmem_i),
    .fetch_rsp_i    (icache2if_o),
    .mmu_rsp_i      (dmem2mmu_o),
    .dmem_bus_rsp_i (dmem2dbus_o),
    .bmem_bus_rsp_i (bmem2dbus_o),
    .failed_o       ()
);

// ==== testbench/mem_top_tb.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_top_tb;
    import mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;

    logic            clk = 1'b0;
    logic            rst_n;
    type_if2icache_s fetch_req;
    type_icache2if_s icache2if;
    type_mmu2dmem_s  mmu_req;
    type_dmem2mmu_s  dmem2mmu;
    type_dbus2peri_s dbus;
    type_peri2dbus_s dmem2dbus, bmem2dbus;
    logic            flush, dmem_sel, bmem_sel;
    logic [31:0]     main_shadow [`DMEM_DEPTH_WORDS];
    logic [31:0]     boot_shadow [`BMEM_DEPTH_WORDS];
    time             dbus_ack_t, mmu_valid_t;  // When each port last finished

    mem_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .if2icache_i    (fetch_req),
        .icache2if_o    (icache2if),
        .mmu2dmem_i     (mmu_req),
        .dmem2mmu_o     (dmem2mmu),
        .dbus2dmem_i    (dbus),
        .dmem2dbus_o    (dmem2dbus),
        .bmem2dbus_o    (bmem2dbus),
        .dcache_flush_i (flush),
        .dmem_sel_i     (dmem_sel),
        .bmem_sel_i     (bmem_sel)
    );

    always #50 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    always @(negedge clk) begin
        if (dut.props.failed_o) fail_now("A handshake property of mem_top failed");
    end

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else fail_now($sformatf("[ERROR] time %0t: %s returned %08h, expected %08h",
                                    $time, what, got, exp));
    endtask

    // Byte-enabled update of a shadow word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic dbus_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                                 input logic [3:0] sel, input logic we, input logic to_boot,
                                 output logic [31:0] rdata);
        int   cnt;
        logic ack;
        cnt = 0;
        ack = 1'b0;
        @(posedge clk);
        dbus.addr     <= addr;
        dbus.w_data   <= wdata;
        dbus.sel_byte <= sel;
        dbus.w_en     <= we;
        dbus.cyc      <= 1'b1;
        dbus.stb      <= 1'b1;
        dmem_sel      <= ~to_boot;
        bmem_sel      <= to_boot;
        while (!ack) begin
            @(negedge clk);
            ack = to_boot ? bmem2dbus.ack : dmem2dbus.ack;
            cnt++;
            if (!ack && cnt > TIMEOUT_CYCLES) begin
                fail_now($sformatf("Data bus cycle at address %08h was never acknowledged", addr));
            end
        end
        rdata      = to_boot ? bmem2dbus.r_data : dmem2dbus.r_data;
        dbus_ack_t = $time;
        @(posedge clk);  // End of cycle
        dbus.cyc <= 1'b0;
        dbus.stb <= 1'b0;
        dbus.w_en <= 1'b0;
        dmem_sel <= 1'b0;
        bmem_sel <= 1'b0;
    endtask

    task automatic dbus_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] sel, input logic to_boot);
        logic [31:0] unused_rdata;
        dbus_transfer(addr, data, sel, 1'b1, to_boot, unused_rdata);
        if (to_boot) begin
            boot_shadow[addr[`BMEM_ADDR_BITS+1:2]] =
                merge_bytes(boot_shadow[addr[`BMEM_ADDR_BITS+1:2]], data, sel);
        end else begin
            main_shadow[addr[`DMEM_ADDR_BITS+1:2]] =
                merge_bytes(main_shadow[addr[`DMEM_ADDR_BITS+1:2]], data, sel);
        end
    endtask

    task automatic dbus_read(input logic [31:0] addr, input logic to_boot);
        logic [31:0] rdata;
        dbus_transfer(addr, 32'h0, 4'hF, 1'b0, to_boot, rdata);
        if (to_boot) check_word("Boot memory read", rdata, boot_shadow[addr[`BMEM_ADDR_BITS+1:2]]);
        else check_word("LSU read", rdata, main_shadow[addr[`DMEM_ADDR_BITS+1:2]]);
    endtask

    task automatic mmu_read(input logic [31:0] addr);
        int cnt;
        cnt = 0;
        @(posedge clk);
        mmu_req.paddr <= addr;
        mmu_req.r_req <= 1'b1;
        do begin
            @(negedge clk);
            cnt++;
            if (!dmem2mmu.r_valid && cnt > TIMEOUT_CYCLES) begin
                fail_now($sformatf("MMU read at address %08h never got r_valid", addr));
            end
        end while (!dmem2mmu.r_valid);
        mmu_valid_t = $time;
        check_word("MMU read", dmem2mmu.r_data, main_shadow[addr[`DMEM_ADDR_BITS+1:2]]);
        @(posedge clk);
        mmu_req.r_req <= 1'b0;
    endtask

    task automatic fetch(input logic [31:0] addr);
        int          cnt;
        logic [31:0] exp;
        cnt = 0;
        if (addr[31:28] == 4'h1) begin  // Boot region
            exp = boot_shadow[addr[`BMEM_ADDR_BITS+1:2]];
        end else begin
            exp = main_shadow[addr[`DMEM_ADDR_BITS+1:2]];
        end
        @(posedge clk);
        fetch_req.addr <= addr;
        fetch_req.req  <= 1'b1;
        do begin
            @(negedge clk);
            cnt++;
            if (!icache2if.ack && cnt > TIMEOUT_CYCLES) begin
                fail_now($sformatf("Fetch at address %08h was never acknowledged", addr));
            end
        end while (!icache2if.ack);
        check_word("Fetch", icache2if.r_data, exp);
        @(posedge clk);
        fetch_req.req <= 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] addrs [8];
        rst_n     = 1'b0;
        fetch_req = '0;
        mmu_req   = '0;
        dbus      = '0;
        flush     = 1'b0;
        dmem_sel  = 1'b0;
        bmem_sel  = 1'b0;
        void'($urandom(32'h1086_b450));
        @(posedge clk);
        // Requests held in reset must stay unanswered
        dbus.cyc      <= 1'b1;
        dbus.stb      <= 1'b1;
        dmem_sel      <= 1'b1;
        mmu_req.r_req <= 1'b1;
        fetch_req.req <= 1'b1;
        repeat (4) @(posedge clk);
        dbus.cyc      <= 1'b0;
        dbus.stb      <= 1'b0;
        dmem_sel      <= 1'b0;
        mmu_req.r_req <= 1'b0;
        fetch_req.req <= 1'b0;
        rst_n         <= 1'b1;

        repeat (5) begin  // Idle outputs stay quiet
            @(negedge clk);
            assert (!(icache2if.ack || dmem2mmu.r_valid || dmem2dbus.ack || bmem2dbus.ack))
                else fail_now($sformatf("[ERROR] time %0t: response with no request", $time));
        end

        // Lower half of main memory is fetched later
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            addrs[i] = {20'h0, 1'b0, r[8:0], 2'b00};
            dbus_write(addrs[i], $urandom, 4'hF, 1'b0);
            dbus_read(addrs[i], 1'b0);        // Miss fills the line
            r = $urandom;
            dbus_write(addrs[i], $urandom, r[3:0], 1'b0);
            dbus_read(addrs[i], 1'b0);        // Hit on merged copy
        end

        mmu_read(addrs[0]);
        fork
            dbus_read(addrs[1], 1'b0);
            mmu_read(addrs[2]);
        join
        assert (dbus_ack_t < mmu_valid_t)
            else fail_now($sformatf("[ERROR] time %0t: MMU served before the LSU", $time));

        for (int i = 0; i < 8; i++) begin
            fetch(addrs[i]);  // Miss
            fetch(addrs[i]);  // Hit
        end

        for (int i = 0; i < 4; i++) begin
            r = $urandom;
            addr = {4'h1, 20'h0, r[5:0], 2'b00};
            dbus_write(addr, $urandom, 4'hF, 1'b1);
            dbus_read(addr, 1'b1);
            fetch(addr);
        end

        // Upper half is never fetched
        r = $urandom;
        addr = {20'h0, 1'b1, r[8:0], 2'b00};
        dbus_write(addr, $urandom, 4'hF, 1'b0);
        dbus_read(addr, 1'b0);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        dbus_write(addr, $urandom, 4'hF, 1'b0);
        mmu_read(addr);
        dbus_read(addr, 1'b0);

        repeat (2) @(posedge clk);
        if (!dut.props.failed_o) begin
            $display("Test OK");
            $finish;
        end else begin
            fail_now("A handshake property of mem_top failed");
        end
    end

endmodule : mem_top_tb

// ==== src.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/dmem_arbiter.sv
rtl/icache.sv
rtl/dcache.sv
rtl/dualport_mem.sv
rtl/boot_mem.sv
rtl/mem_top.sv
testbench/mem_top_properties.sv
testbench/mem_top_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module mem_top_tb -f src.f
	@out=$$(./obj_dir/Vmem_top_tb); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
